// ==== hw/versatPkg.sv ====
package versatPkg;

   localparam int DATA_W      = 32;
   localparam int MEM_ADDR_W  = 8;
   localparam int PERIOD_W    = 5;
   localparam int NUM_MEMS    = 2;
   localparam int NUM_FLOW    = 2 * NUM_MEMS;
   localparam int SEL_W       = 3;
   localparam int UNIT_W      = 1;
   localparam int FIELD_W     = 3;
   localparam int HOST_ADDR_W = 16;

   // config field indices
   localparam logic [FIELD_W-1:0] F_ITER   = 3'd0;
   localparam logic [FIELD_W-1:0] F_PERIOD = 3'd1;
   localparam logic [FIELD_W-1:0] F_START  = 3'd2;
   localparam logic [FIELD_W-1:0] F_SHIFT  = 3'd3;
   localparam logic [FIELD_W-1:0] F_INCR   = 3'd4;
   localparam logic [FIELD_W-1:0] F_DELAY  = 3'd5;
   localparam logic [FIELD_W-1:0] F_FLAGS  = 3'd6;
   localparam logic [FIELD_W-1:0] F_RUN    = 3'd7;

   // flag bits of a flags write, just above sel
   localparam int FLAG_WRITE = SEL_W;
   localparam int FLAG_REV   = SEL_W + 1;

   typedef struct packed {
      logic [MEM_ADDR_W-1:0] iterations;
      logic [PERIOD_W-1:0]   period;
      logic [MEM_ADDR_W-1:0] start;
      logic [MEM_ADDR_W-1:0] shift;
      logic [MEM_ADDR_W-1:0] incr;
      logic [PERIOD_W-1:0]   delay;
      logic [SEL_W-1:0]      sel;
      logic                  write;
      logic                  reverse;
   } portCfgT;

   // isCfg is the msb in both views
   typedef struct packed {
      logic                                     isCfg;
      logic [UNIT_W-1:0]                        unit;
      logic [HOST_ADDR_W-UNIT_W-MEM_ADDR_W-2:0] pad;
      logic [MEM_ADDR_W-1:0]                    memAddr;
   } memAccT;

   typedef struct packed {
      logic                                  isCfg;
      logic [UNIT_W-1:0]                     unit;
      logic                                  port;
      logic [FIELD_W-1:0]                    field;
      logic [HOST_ADDR_W-UNIT_W-FIELD_W-3:0] pad;
   } cfgAccT;

   typedef union packed {
      memAccT mem;
      cfgAccT cfg;
   } hostAddrT;

   typedef struct packed {
      logic               valid;
      logic [UNIT_W-1:0]  unit;
      logic               port;
      logic [FIELD_W-1:0] field;
      logic [DATA_W-1:0]  data;
   } cfgWrT;

   typedef struct packed {
      logic                  valid;
      logic [UNIT_W-1:0]     unit;
      logic                  we;
      logic [MEM_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } memReqT;

endpackage

// ==== hw/addrGen.sv ====
`timescale 1ns/1ps

module addrGen (
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             run,
   input  versatPkg::portCfgT               cfg,
   output logic [versatPkg::MEM_ADDR_W-1:0] addr,
   output logic                             en,
   output logic                             done
);

   logic                             active;
   logic [versatPkg::PERIOD_W-1:0]   delayCnt;
   logic [versatPkg::PERIOD_W-1:0]   perCnt;
   logic [versatPkg::MEM_ADDR_W-1:0] iterCnt;
   logic [versatPkg::MEM_ADDR_W-1:0] base;
   logic [versatPkg::MEM_ADDR_W-1:0] offset;
   logic [versatPkg::MEM_ADDR_W-1:0] linAddr;

   assign en      = active && (delayCnt == '0);
   assign linAddr = base + offset;

   // mirror address bits when reverse is set
   always_comb
   begin
      for (int k = 0; k < versatPkg::MEM_ADDR_W; k++)
      begin
         addr[k] = cfg.reverse ? linAddr[versatPkg::MEM_ADDR_W-1-k] : linAddr[k];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         active   <= 1'b0;
         done     <= 1'b1;
         delayCnt <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         base     <= '0;
         offset   <= '0;
      end
      else if (run && (cfg.iterations != '0))
      begin
         active   <= 1'b1;
         done     <= 1'b0;
         delayCnt <= cfg.delay;
         perCnt   <= '0;
         iterCnt  <= '0;
         base     <= cfg.start;
         offset   <= '0;
      end
      else if (active)
      begin
         if (delayCnt != '0)
            delayCnt <= delayCnt - 1'b1;
         else if (perCnt == cfg.period - 1'b1)
         begin
            // end of inner loop, step the outer base
            perCnt <= '0;
            offset <= '0;
            base   <= base + cfg.shift;
            if (iterCnt == cfg.iterations - 1'b1)
            begin
               active <= 1'b0;
               done   <= 1'b1;
            end
            else
               iterCnt <= iterCnt + 1'b1;
         end
         else
         begin
            perCnt <= perCnt + 1'b1;
            offset <= offset + cfg.incr;
         end
      end
   end

endmodule

// ==== hw/dualPortRam.sv ====
`timescale 1ns/1ps

module dualPortRam (
   input  logic                             clk,
   input  logic                             enA,
   input  logic                             weA,
   input  logic [versatPkg::MEM_ADDR_W-1:0] addrA,
   input  logic [versatPkg::DATA_W-1:0]     dataA,
   output logic [versatPkg::DATA_W-1:0]     qA,
   input  logic                             enB,
   input  logic                             weB,
   input  logic [versatPkg::MEM_ADDR_W-1:0] addrB,
   input  logic [versatPkg::DATA_W-1:0]     dataB,
   output logic [versatPkg::DATA_W-1:0]     qB
);

   logic [versatPkg::DATA_W-1:0] mem [2**versatPkg::MEM_ADDR_W];

   // read-first on both ports, q holds when idle
   always_ff @(posedge clk)
   begin
      if (enA)
      begin
         if (weA)
            mem[addrA] <= dataA;
         qA <= mem[addrA];
      end
      if (enB)
      begin
         if (weB)
            mem[addrB] <= dataB;
         qB <= mem[addrB];
      end
   end

endmodule

// ==== hw/memUnit.sv ====
`timescale 1ns/1ps

module memUnit #(
   parameter int UNIT_IDX = 0
) (
   input  logic                                                clk,
   input  logic                                                rstN,
   input  versatPkg::cfgWrT                                    cfgWr,
   input  versatPkg::memReqT                                   memReq,
   input  logic [versatPkg::NUM_FLOW-1:0][versatPkg::DATA_W-1:0] flowWords,
   input  logic [versatPkg::DATA_W-1:0]                        streamIn,
   output logic [1:0][versatPkg::DATA_W-1:0]                   portOut,
   output logic [1:0]                                          done
);

   versatPkg::portCfgT [1:0]           cfgR;
   logic [1:0][versatPkg::DATA_W-1:0]  inWord;
   logic [1:0][versatPkg::MEM_ADDR_W-1:0] genAddr;
   logic [1:0]                         genEn;
   logic [1:0]                         runPort;
   logic                               cfgHit;
   logic                               runHit;
   logic                               hostHit;
   logic                               ramEnA;
   logic                               ramWeA;
   logic [versatPkg::MEM_ADDR_W-1:0]   ramAddrA;
   logic [versatPkg::DATA_W-1:0]       ramDataA;

   assign cfgHit     = cfgWr.valid && (int'(cfgWr.unit) == UNIT_IDX);
   assign runHit     = cfgHit && (cfgWr.field == versatPkg::F_RUN);
   assign runPort[0] = runHit && !cfgWr.port;
   assign runPort[1] = runHit && cfgWr.port;
   assign hostHit    = memReq.valid && (int'(memReq.unit) == UNIT_IDX);

   always_ff @(posedge clk)
   begin
      if (!rstN)
         cfgR <= '0;
      else if (cfgHit)
      begin
         case (cfgWr.field)
            versatPkg::F_ITER:
               cfgR[cfgWr.port].iterations <= cfgWr.data[versatPkg::MEM_ADDR_W-1:0];
            versatPkg::F_PERIOD:
               cfgR[cfgWr.port].period <= cfgWr.data[versatPkg::PERIOD_W-1:0];
            versatPkg::F_START:
               cfgR[cfgWr.port].start <= cfgWr.data[versatPkg::MEM_ADDR_W-1:0];
            versatPkg::F_SHIFT:
               cfgR[cfgWr.port].shift <= cfgWr.data[versatPkg::MEM_ADDR_W-1:0];
            versatPkg::F_INCR:
               cfgR[cfgWr.port].incr <= cfgWr.data[versatPkg::MEM_ADDR_W-1:0];
            versatPkg::F_DELAY:
               cfgR[cfgWr.port].delay <= cfgWr.data[versatPkg::PERIOD_W-1:0];
            versatPkg::F_FLAGS:
            begin
               cfgR[cfgWr.port].sel     <= cfgWr.data[versatPkg::SEL_W-1:0];
               cfgR[cfgWr.port].write   <= cfgWr.data[versatPkg::FLAG_WRITE];
               cfgR[cfgWr.port].reverse <= cfgWr.data[versatPkg::FLAG_REV];
            end
            default: ;
         endcase
      end
   end

   // input select: bus word by index, or the external stream
   always_comb
   begin
      for (int p = 0; p < 2; p++)
      begin
         inWord[p] = '0;
         if (int'(cfgR[p].sel) == versatPkg::NUM_FLOW)
            inWord[p] = streamIn;
         for (int w = 0; w < versatPkg::NUM_FLOW; w++)
         begin
            if (int'(cfgR[p].sel) == w)
               inWord[p] = flowWords[w];
         end
      end
   end

   for (genvar p = 0; p < 2; p++)
   begin : genPort
      addrGen i_addrGen (
         .clk  (clk),
         .rstN (rstN),
         .run  (runPort[p]),
         .cfg  (cfgR[p]),
         .addr (genAddr[p]),
         .en   (genEn[p]),
         .done (done[p])
      );
   end

   // host request wins port A
   assign ramEnA   = hostHit || genEn[0];
   assign ramWeA   = hostHit ? memReq.we : (genEn[0] && cfgR[0].write);
   assign ramAddrA = hostHit ? memReq.addr : genAddr[0];
   assign ramDataA = hostHit ? memReq.data : inWord[0];

   dualPortRam i_dualPortRam (
      .clk   (clk),
      .enA   (ramEnA),
      .weA   (ramWeA),
      .addrA (ramAddrA),
      .dataA (ramDataA),
      .qA    (portOut[0]),
      .enB   (genEn[1]),
      .weB   (genEn[1] && cfgR[1].write),
      .addrB (genAddr[1]),
      .dataB (inWord[1]),
      .qB    (portOut[1])
   );

endmodule

// ==== hw/hostDecoder.sv ====
`timescale 1ns/1ps

module hostDecoder (
   input  logic                                                clk,
   input  logic                                                rstN,
   input  logic                                                hostValid,
   input  logic                                                hostWe,
   input  versatPkg::hostAddrT                                 hostAddr,
   input  logic [versatPkg::DATA_W-1:0]                        hostWdata,
   output versatPkg::cfgWrT                                    cfgWr,
   output versatPkg::memReqT                                   memReq,
   input  logic [versatPkg::NUM_MEMS-1:0][versatPkg::DATA_W-1:0] unitPortA,
   output logic [versatPkg::DATA_W-1:0]                        hostRdata,
   output logic                                                hostRvalid
);

   logic [versatPkg::UNIT_W-1:0] rdUnit;

   // config view, writes only
   always_comb
   begin
      cfgWr.valid = hostValid && hostAddr.cfg.isCfg && hostWe;
      cfgWr.unit  = hostAddr.cfg.unit;
      cfgWr.port  = hostAddr.cfg.port;
      cfgWr.field = hostAddr.cfg.field;
      cfgWr.data  = hostWdata;
   end

   // memory view
   always_comb
   begin
      memReq.valid = hostValid && !hostAddr.mem.isCfg;
      memReq.unit  = hostAddr.mem.unit;
      memReq.we    = hostWe;
      memReq.addr  = hostAddr.mem.memAddr;
      memReq.data  = hostWdata;
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
         hostRvalid <= 1'b0;
      else
         hostRvalid <= hostValid && !hostAddr.mem.isCfg && !hostWe;
   end

   always_ff @(posedge clk)
   begin
      rdUnit <= hostAddr.mem.unit;
   end

   // ram output lands the cycle after the strobe
   assign hostRdata = unitPortA[rdUnit];

endmodule

// ==== hw/flowBus.sv ====
`timescale 1ns/1ps

module flowBus (
   input  logic                                                     clk,
   input  logic                                                     rstN,
   input  logic [versatPkg::NUM_MEMS-1:0][1:0][versatPkg::DATA_W-1:0] portOut,
   input  logic [versatPkg::NUM_MEMS-1:0][1:0]                      done,
   output logic [versatPkg::NUM_FLOW-1:0][versatPkg::DATA_W-1:0]    flowWords,
   output logic                                                     busy
);

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         flowWords <= '0;
         busy      <= 1'b0;
      end
      else
      begin
         // word 2*u is port A of unit u, 2*u+1 port B
         for (int u = 0; u < versatPkg::NUM_MEMS; u++)
         begin
            for (int p = 0; p < 2; p++)
            begin
               flowWords[2*u+p] <= portOut[u][p];
            end
         end
         busy <= |(~done);
      end
   end

endmodule

// ==== hw/versatTop.sv ====
`timescale 1ns/1ps

module versatTop (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         hostValid,
   input  logic                         hostWe,
   input  versatPkg::hostAddrT          hostAddr,
   input  logic [versatPkg::DATA_W-1:0] hostWdata,
   output logic [versatPkg::DATA_W-1:0] hostRdata,
   output logic                         hostRvalid,
   input  logic [versatPkg::DATA_W-1:0] streamIn,
   output logic                         busy
);

   versatPkg::cfgWrT                                            cfgWr;
   versatPkg::memReqT                                           memReq;
   logic [versatPkg::NUM_FLOW-1:0][versatPkg::DATA_W-1:0]       flowWords;
   logic [versatPkg::NUM_MEMS-1:0][1:0][versatPkg::DATA_W-1:0]  portOut;
   logic [versatPkg::NUM_MEMS-1:0][1:0]                         unitDone;
   logic [versatPkg::NUM_MEMS-1:0][versatPkg::DATA_W-1:0]       unitPortA;

   hostDecoder i_hostDecoder (
      .clk        (clk),
      .rstN       (rstN),
      .hostValid  (hostValid),
      .hostWe     (hostWe),
      .hostAddr   (hostAddr),
      .hostWdata  (hostWdata),
      .cfgWr      (cfgWr),
      .memReq     (memReq),
      .unitPortA  (unitPortA),
      .hostRdata  (hostRdata),
      .hostRvalid (hostRvalid)
   );

   for (genvar u = 0; u < versatPkg::NUM_MEMS; u++)
   begin : genMem
      memUnit #(
         .UNIT_IDX (u)
      ) i_memUnit (
         .clk       (clk),
         .rstN      (rstN),
         .cfgWr     (cfgWr),
         .memReq    (memReq),
         .flowWords (flowWords),
         .streamIn  (streamIn),
         .portOut   (portOut[u]),
         .done      (unitDone[u])
      );

      assign unitPortA[u] = portOut[u][0];
   end

   flowBus i_flowBus (
      .clk       (clk),
      .rstN      (rstN),
      .portOut   (portOut),
      .done      (unitDone),
      .flowWords (flowWords),
      .busy      (busy)
   );

endmodule

// ==== dv/versatTb.sv ====
`timescale 1ns/1ps

module versatTb;

   logic                         clk;
   logic                         rstN;
   logic                         hostValid;
   logic                         hostWe;
   versatPkg::hostAddrT          hostAddr;
   logic [versatPkg::DATA_W-1:0] hostWdata;
   logic [versatPkg::DATA_W-1:0] hostRdata;
   logic                         hostRvalid;
   logic [versatPkg::DATA_W-1:0] streamIn;
   logic                         busy;

   logic [versatPkg::DATA_W-1:0] streamBase;
   logic [31:0]                  streamCnt;
   logic [7:0]                   cmdQ[$];
   logic [31:0]                  aQ[$];
   logic [31:0]                  bQ[$];
   int                           cmdCount = 0;

   versatTop i_versatTop (
      .clk        (clk),
      .rstN       (rstN),
      .hostValid  (hostValid),
      .hostWe     (hostWe),
      .hostAddr   (hostAddr),
      .hostWdata  (hostWdata),
      .hostRdata  (hostRdata),
      .hostRvalid (hostRvalid),
      .streamIn   (streamIn),
      .busy       (busy)
   );

   // 40 ns period
   always #20 clk = ~clk;

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      assert (actual === expected)
      else
         failRun($sformatf("FAILED time=%0t signal=%s expected=%h actual=%h",
                           $time, name, expected, actual));
   endtask

   // one clock edge, strobe cleared and a new stream word
   task automatic nextCycle();
      @(posedge clk);
      hostValid <= 1'b0;
      hostWe    <= 1'b0;
      streamIn  <= streamBase + streamCnt;
      streamCnt = streamCnt + 1;
   endtask

   task automatic driveHost(input logic we, input logic [15:0] addr,
                            input logic [31:0] data);
      nextCycle();
      hostValid <= 1'b1;
      hostWe    <= we;
      hostAddr  <= addr;
      hostWdata <= data;
   endtask

   // rvalid must show up exactly one cycle after the strobe
   task automatic readCheck(input logic [15:0] addr, input logic [31:0] expected);
      driveHost(1'b0, addr, 32'd0);
      @(negedge clk);
      checkValue("hostRvalid", 32'd0, 32'(hostRvalid));
      nextCycle();
      @(negedge clk);
      checkValue("hostRvalid", 32'd1, 32'(hostRvalid));
      checkValue("hostRdata", expected, hostRdata);
   endtask

   task automatic waitBusy(input logic expectRun);
      if (expectRun)
      begin
         do
         begin
            nextCycle();
            @(negedge clk);
         end while (!busy);
         do
         begin
            nextCycle();
            @(negedge clk);
         end while (busy);
      end
      else
      begin
         // busy would rise two cycles after a real run strobe
         repeat (4)
         begin
            nextCycle();
            @(negedge clk);
            checkValue("busy", 32'd0, 32'(busy));
         end
      end
   endtask

   initial
   begin
      int          fd;
      int          r;
      logic [7:0]  letter;
      logic [31:0] opA;
      logic [31:0] opB;
      logic [1023:0] lineBuf;

      clk        = 1'b0;
      rstN       = 1'b0;
      hostValid  = 1'b0;
      hostWe     = 1'b0;
      hostAddr   = '0;
      hostWdata  = '0;
      streamIn   = '0;
      streamBase = '0;
      streamCnt  = '0;

      fd = $fopen("dv/versatTestdata.txt", "r");
      if (fd == 0)
         failRun("could not open the test data file dv/versatTestdata.txt");
      while (!$feof(fd))
      begin
         r = $fscanf(fd, " %c", letter);
         if (r != 1)
            break;
         if (letter == "#")
            r = $fgets(lineBuf, fd);
         else
         begin
            r = $fscanf(fd, " %h %h", opA, opB);
            if (r != 2)
               failRun("a command line in the test data file is missing its operands");
            cmdQ.push_back(letter);
            aQ.push_back(opA);
            bQ.push_back(opB);
         end
      end
      $fclose(fd);
      if (cmdQ.size() == 0)
         failRun("the test data file holds no commands");
      cmdCount = cmdQ.size();

      repeat (16) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      checkValue("hostRvalid", 32'd0, 32'(hostRvalid));
      checkValue("busy", 32'd0, 32'(busy));

      for (int i = 0; i < cmdCount; i++)
      begin
         case (cmdQ[i])
            "W": driveHost(1'b1, aQ[i][15:0], bQ[i]);
            "G": driveHost(1'b1, aQ[i][15:0], 32'd0);
            "R": readCheck(aQ[i][15:0], bQ[i]);
            "S":
            begin
               streamBase = bQ[i];
               streamCnt  = '0;
               nextCycle();
            end
            "B": waitBusy(bQ[i][0]);
            default: failRun($sformatf("unknown command letter %c in the test data", cmdQ[i]));
         endcase
      end

      $display("Test OK");
      $finish;
   end

   // 300 ns per command on top of the reset time
   initial
   begin
      wait (cmdCount != 0);
      #(cmdCount * 300 + 16 * 40);
      failRun("timeout, the commands did not finish in time");
   end

endmodule

// ==== dv/versatTestdata.txt ====
# each line is a command letter and two hex operands
# W addr data, R addr expected, G addr 0, S 0 base, B 0 expectRun
# preload unit 0
W 0004 3c1a7e05
W 0005 91d4e6b2
W 0006 0f2b9c47
W 0007 e58a1d30
W 000c 7746b2c9
W 000d a0c3f51e
W 000e 5d98047b
W 000f c2e16a8d
W 4010 12345678
R 4010 12345678
R 0006 0f2b9c47
R 000d a0c3f51e
# unit 0 port A reader, start 4 incr 1 period 4 iterations 2 shift 8 delay 1
W 8000 00000002
W 8400 00000004
W 8800 00000004
W 8c00 00000008
W 9000 00000001
W 9400 00000001
# unit 1 port B writer from bus word 0
# strobed one cycle before the reader so its delay is the reader delay plus 3
W e000 00000002
W e400 00000004
W e800 00000020
W ec00 00000004
W f000 00000001
W f400 00000004
W f800 00000008
G fc00 0
G 9c00 0
B 0 1
R 4020 3c1a7e05
R 4021 91d4e6b2
R 4022 0f2b9c47
R 4023 e58a1d30
R 4024 7746b2c9
R 4025 a0c3f51e
R 4026 5d98047b
R 4027 c2e16a8d
# unit 0 port B stores the stream at mirrored addresses 1 to 4
# first address sees base plus 2
W a000 00000001
W a400 00000004
W a800 00000001
W b000 00000001
W b800 0000001c
S 0 000000fe
G bc00 0
B 0 1
R 0080 00000100
R 0040 00000101
R 00c0 00000102
R 0020 00000103
# zero iterations so busy stays low
W c000 00000000
G dc00 0
B 0 0
# host writes on port A while the reader runs
G 9c00 0
W 0001 11111111
W 000e 0badf00d
B 0 1
R 000e 0badf00d
R 0001 11111111
R 0004 3c1a7e05

// ==== vlog.f ====
hw/versatPkg.sv
hw/addrGen.sv
hw/dualPortRam.sv
hw/memUnit.sv
hw/hostDecoder.sv
hw/flowBus.sv
hw/versatTop.sv
dv/versatTb.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f vlog.f --top-module versatTb -o simv; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Test OK$" <<< "$output"; then
   exit 0
else
   exit 1
fi
